//--- design/rvIsaPkg.sv
package rvIsaPkg;

    localparam int xlen = 32;

    typedef logic [4:0]      regAddrT;
    typedef logic [xlen-1:0] wordT;

    // major opcodes of the kept subset, bits [6:0]
    typedef enum logic [6:0] {
        opOp    = 7'b0110011,  // register-register ALU
        opOpImm = 7'b0010011,  // register-immediate ALU
        opLui   = 7'b0110111,
        opHalt  = 7'b0001011   // custom-0 space
    } opcodeT;

    // ------------------------------------------------------------------------
    // funct3 encodings for OP and OP-IMM
    // ------------------------------------------------------------------------
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct7 value selecting sub and sra
    localparam logic [6:0] f7Alt = 7'b0100000;

    // addi x0,x0,0
    localparam wordT nopWord = 32'h0000_0013;

endpackage

//--- design/pipePkg.sv
package pipePkg;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

    // operand source, in falling priority after fromReg
    typedef enum logic [2:0] {
        fromReg = 3'd0,
        fromXmA = 3'd1,
        fromXmB = 3'd2,
        fromMwA = 3'd3,
        fromMwB = 3'd4
    } fwdSelT;

    // one decoded slot; all zero is a bubble
    typedef struct packed {
        aluOpT             aluOp;
        logic              useImm;
        logic              writeEn;  // only set with rd != x0
        logic              isLui;
        logic              isHalt;
        rvIsaPkg::regAddrT rd;
        rvIsaPkg::regAddrT rs1;      // x0 when unused
        rvIsaPkg::regAddrT rs2;      // x0 when unused
        rvIsaPkg::wordT    imm;
    } slotCtrlT;

    // one slot in execute/memory or memory/writeback
    typedef struct packed {
        logic              writeEn;
        logic              isHalt;
        rvIsaPkg::regAddrT rd;
        rvIsaPkg::wordT    result;
    } slotExT;

    typedef struct packed {
        logic              valid;
        rvIsaPkg::regAddrT rd;
        rvIsaPkg::wordT    data;
    } retireT;

    typedef struct packed {
        rvIsaPkg::wordT slotA;  // lower address
        rvIsaPkg::wordT slotB;
    } packetT;

endpackage

//--- design/fetchUnit.sv
module fetchUnit #(
    parameter rvIsaPkg::wordT pcResetValue = '0
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             split,
    input  pipePkg::packetT  fetchPacket,
    output rvIsaPkg::wordT   fetchAddr,
    output pipePkg::packetT  fdPacket
);

    localparam rvIsaPkg::wordT pcStart = {pcResetValue[rvIsaPkg::xlen-1:3], 3'b000};

    // ------------------------------------------------------------------------
    // program counter
    // ------------------------------------------------------------------------
    // packet aligned, so it only ever moves by eight
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fetchAddr <= pcStart;
        end else if (!split) begin
            fetchAddr <= fetchAddr + rvIsaPkg::wordT'(8);
        end
    end

    // ------------------------------------------------------------------------
    // fetch/decode register
    // ------------------------------------------------------------------------
    // on a split slot A already went down the pipe, so only B stays
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fdPacket.slotA <= rvIsaPkg::nopWord;
            fdPacket.slotB <= rvIsaPkg::nopWord;
        end else if (split) begin
            fdPacket.slotA <= rvIsaPkg::nopWord;  // slotB held
        end else begin
            fdPacket <= fetchPacket;
        end
    end

endmodule

//--- design/decodeSlot.sv
module decodeSlot (
    input  rvIsaPkg::wordT     instr,
    output pipePkg::slotCtrlT  slotCtrl
);

    rvIsaPkg::opcodeT  opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    rvIsaPkg::regAddrT rd;
    rvIsaPkg::wordT    immI;
    rvIsaPkg::wordT    immU;
    logic              isRegOp;
    logic              altFunct;
    logic              writes;
    pipePkg::aluOpT    aluOp;

    // ------------------------------------------------------------------------
    // fields and immediates
    // ------------------------------------------------------------------------
    assign opcode   = rvIsaPkg::opcodeT'(instr[6:0]);
    assign rd       = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign immI     = {{20{instr[31]}}, instr[31:20]};
    assign immU     = {instr[31:12], 12'b0};
    assign isRegOp  = (opcode == rvIsaPkg::opOp);
    assign altFunct = (funct7 == rvIsaPkg::f7Alt);

    always_comb begin
        case (funct3)
            rvIsaPkg::f3AddSub: aluOp = (isRegOp && altFunct) ? pipePkg::aluSub : pipePkg::aluAdd;
            rvIsaPkg::f3Sll:    aluOp = pipePkg::aluSll;
            rvIsaPkg::f3Slt:    aluOp = pipePkg::aluSlt;
            rvIsaPkg::f3Sltu:   aluOp = pipePkg::aluSltu;
            rvIsaPkg::f3Xor:    aluOp = pipePkg::aluXor;
            rvIsaPkg::f3SrlSra: aluOp = altFunct ? pipePkg::aluSra : pipePkg::aluSrl;
            rvIsaPkg::f3Or:     aluOp = pipePkg::aluOr;
            default:            aluOp = pipePkg::aluAnd;
        endcase
    end

    // ------------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------------
    always_comb begin
        slotCtrl       = '0;
        writes         = 1'b0;
        slotCtrl.rd    = rd;
        slotCtrl.aluOp = aluOp;
        case (opcode)
            rvIsaPkg::opOp: begin
                writes       = 1'b1;
                slotCtrl.rs1 = instr[19:15];
                slotCtrl.rs2 = instr[24:20];
            end
            rvIsaPkg::opOpImm: begin
                writes          = 1'b1;
                slotCtrl.useImm = 1'b1;
                slotCtrl.rs1    = instr[19:15];
                slotCtrl.imm    = immI;  // shamt sits in the low five bits
            end
            rvIsaPkg::opLui: begin
                writes         = 1'b1;
                slotCtrl.isLui = 1'b1;
                slotCtrl.imm   = immU;
            end
            rvIsaPkg::opHalt: begin
                slotCtrl.isHalt = 1'b1;
            end
            default: begin
                writes = 1'b0;  // anything else retires as a nop
            end
        endcase
        // x0 writes dropped here, nothing downstream checks rd
        slotCtrl.writeEn = writes && (rd != '0);
    end

endmodule

//--- design/regFile.sv
module regFile (
    input  logic                     clock,
    input  logic                     reset,
    input  rvIsaPkg::regAddrT [3:0]  readAddr,
    output rvIsaPkg::wordT    [3:0]  readData,
    input  pipePkg::retireT          writeA,
    input  pipePkg::retireT          writeB
);

    rvIsaPkg::wordT regs [1:31];  // x0 not stored

    // B is younger, so its write lands last
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (writeA.valid) begin
                regs[writeA.rd] <= writeA.data;
            end
            if (writeB.valid) begin
                regs[writeB.rd] <= writeB.data;
            end
        end
    end

    // write-through on all four ports
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (readAddr[p] == '0) begin
                readData[p] = '0;
            end else if (writeB.valid && (writeB.rd == readAddr[p])) begin
                readData[p] = writeB.data;
            end else if (writeA.valid && (writeA.rd == readAddr[p])) begin
                readData[p] = writeA.data;
            end else begin
                readData[p] = regs[readAddr[p]];
            end
        end
    end

endmodule

//--- design/issueControl.sv
module issueControl (
    input  logic                    clock,
    input  logic                    reset,
    input  pipePkg::slotCtrlT       ctrlA,
    input  pipePkg::slotCtrlT       ctrlB,
    input  rvIsaPkg::wordT [3:0]    readData,  // A rs1, A rs2, B rs1, B rs2
    output logic                    split,
    output pipePkg::slotCtrlT       dxA,
    output pipePkg::slotCtrlT       dxB,
    output rvIsaPkg::wordT [1:0]    dxDataA,
    output rvIsaPkg::wordT [1:0]    dxDataB
);

    logic readsA;
    logic overwritesA;

    // ------------------------------------------------------------------------
    // intra-packet hazard
    // ------------------------------------------------------------------------
    // unused rs fields are x0 and writeEn implies rd != x0
    assign readsA      = (ctrlA.rd == ctrlB.rs1) || (ctrlA.rd == ctrlB.rs2);
    assign overwritesA = ctrlB.writeEn && (ctrlA.rd == ctrlB.rd);
    assign split       = ctrlA.writeEn && (readsA || overwritesA);

    // ------------------------------------------------------------------------
    // decode/execute register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dxA <= '0;
            dxB <= '0;
        end else begin
            dxA <= ctrlA;
            dxB <= split ? pipePkg::slotCtrlT'('0) : ctrlB;  // B issues next cycle
        end
    end

    always_ff @(posedge clock) begin
        dxDataA <= readData[1:0];
        dxDataB <= readData[3:2];
    end

endmodule

//--- design/bypassAlu.sv
module bypassAlu (
    input  pipePkg::slotCtrlT     dx,
    input  rvIsaPkg::wordT [1:0]  regData,  // rs1 then rs2
    input  pipePkg::slotExT       xmA,
    input  pipePkg::slotExT       xmB,
    input  pipePkg::slotExT       mwA,
    input  pipePkg::slotExT       mwB,
    output rvIsaPkg::wordT        result
);

    rvIsaPkg::regAddrT rsIdx   [2];
    pipePkg::fwdSelT   fwdSel  [2];
    rvIsaPkg::wordT    operand [2];
    rvIsaPkg::wordT    opA;
    rvIsaPkg::wordT    opB;

    assign rsIdx[0] = dx.rs1;
    assign rsIdx[1] = dx.rs2;

    // ------------------------------------------------------------------------
    // forwarding, youngest producer first
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (xmA.writeEn && (xmA.rd == rsIdx[i]))      fwdSel[i] = pipePkg::fromXmA;
            else if (xmB.writeEn && (xmB.rd == rsIdx[i])) fwdSel[i] = pipePkg::fromXmB;
            else if (mwA.writeEn && (mwA.rd == rsIdx[i])) fwdSel[i] = pipePkg::fromMwA;
            else if (mwB.writeEn && (mwB.rd == rsIdx[i])) fwdSel[i] = pipePkg::fromMwB;
            else                                          fwdSel[i] = pipePkg::fromReg;

            case (fwdSel[i])
                pipePkg::fromXmA: operand[i] = xmA.result;
                pipePkg::fromXmB: operand[i] = xmB.result;
                pipePkg::fromMwA: operand[i] = mwA.result;
                pipePkg::fromMwB: operand[i] = mwB.result;
                default:          operand[i] = regData[i];
            endcase
        end
    end

    assign opA = operand[0];
    assign opB = dx.useImm ? dx.imm : operand[1];

    // ------------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------------
    always_comb begin
        if (dx.isLui) begin
            result = dx.imm;
        end else begin
            case (dx.aluOp)
                pipePkg::aluSub:  result = opA - opB;
                pipePkg::aluSll:  result = opA << opB[4:0];
                pipePkg::aluSlt:  result = rvIsaPkg::wordT'($signed(opA) < $signed(opB));
                pipePkg::aluSltu: result = rvIsaPkg::wordT'(opA < opB);
                pipePkg::aluXor:  result = opA ^ opB;
                pipePkg::aluSrl:  result = opA >> opB[4:0];
                pipePkg::aluSra:  result = rvIsaPkg::wordT'($signed(opA) >>> opB[4:0]);
                pipePkg::aluOr:   result = opA | opB;
                pipePkg::aluAnd:  result = opA & opB;
                default:          result = opA + opB;
            endcase
        end
    end

endmodule

//--- design/retireStage.sv
module retireStage #(
    parameter int counterWidth = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  pipePkg::slotCtrlT        dxA,
    input  pipePkg::slotCtrlT        dxB,
    input  rvIsaPkg::wordT           resultA,
    input  rvIsaPkg::wordT           resultB,
    output pipePkg::slotExT          xmA,
    output pipePkg::slotExT          xmB,
    output pipePkg::slotExT          mwA,
    output pipePkg::slotExT          mwB,
    output pipePkg::retireT          retireA,
    output pipePkg::retireT          retireB,
    output logic                     halted,
    output logic [counterWidth-1:0]  counterOut
);

    logic [counterWidth-1:0] cycleCount;
    logic                    haltSeen;

    // ------------------------------------------------------------------------
    // execute/memory and memory/writeback
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            xmA <= '0;
            xmB <= '0;
            mwA <= '0;
            mwB <= '0;
        end else begin
            xmA <= '{writeEn: dxA.writeEn, isHalt: dxA.isHalt, rd: dxA.rd, result: resultA};
            xmB <= '{writeEn: dxB.writeEn, isHalt: dxB.isHalt, rd: dxB.rd, result: resultB};
            mwA <= xmA;  // no memory access left, plain stage
            mwB <= xmB;
        end
    end

    assign retireA = '{valid: mwA.writeEn, rd: mwA.rd, data: mwA.result};
    assign retireB = '{valid: mwB.writeEn, rd: mwB.rd, data: mwB.result};

    // ------------------------------------------------------------------------
    // halt and cycle counter
    // ------------------------------------------------------------------------
    assign haltSeen = mwA.isHalt || mwB.isHalt;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cycleCount <= '0;
            halted     <= 1'b0;
            counterOut <= '0;
        end else begin
            cycleCount <= cycleCount + counterWidth'(1);
            if (haltSeen && !halted) begin
                halted     <= 1'b1;
                counterOut <= cycleCount + counterWidth'(1);  // counts this edge too
            end
        end
    end

endmodule

//--- design/dualIssueCore.sv
module dualIssueCore #(
    parameter rvIsaPkg::wordT pcResetValue = '0,
    parameter int             counterWidth = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    output rvIsaPkg::wordT           fetchAddr,
    input  pipePkg::packetT          fetchPacket,
    output pipePkg::retireT          retireA,
    output pipePkg::retireT          retireB,
    output logic                     halted,
    output logic [counterWidth-1:0]  counterOut
);

    logic                     split;
    pipePkg::packetT          fdPacket;
    pipePkg::slotCtrlT        ctrlA;
    pipePkg::slotCtrlT        ctrlB;
    rvIsaPkg::regAddrT [3:0]  readAddr;
    rvIsaPkg::wordT    [3:0]  readData;
    pipePkg::slotCtrlT        dxA;
    pipePkg::slotCtrlT        dxB;
    rvIsaPkg::wordT    [1:0]  dxDataA;
    rvIsaPkg::wordT    [1:0]  dxDataB;
    rvIsaPkg::wordT           resultA;
    rvIsaPkg::wordT           resultB;
    pipePkg::slotExT          xmA;
    pipePkg::slotExT          xmB;
    pipePkg::slotExT          mwA;
    pipePkg::slotExT          mwB;

    assign readAddr = {ctrlB.rs2, ctrlB.rs1, ctrlA.rs2, ctrlA.rs1};

    fetchUnit #(.pcResetValue(pcResetValue)) fetch (
        .clock(clock), .reset(reset), .split(split),
        .fetchPacket(fetchPacket), .fetchAddr(fetchAddr), .fdPacket(fdPacket)
    );

    decodeSlot decodeA (.instr(fdPacket.slotA), .slotCtrl(ctrlA));
    decodeSlot decodeB (.instr(fdPacket.slotB), .slotCtrl(ctrlB));

    // writeback straight from the retire records
    regFile regs (
        .clock(clock), .reset(reset), .readAddr(readAddr), .readData(readData),
        .writeA(retireA), .writeB(retireB)
    );

    issueControl issue (
        .clock(clock), .reset(reset), .ctrlA(ctrlA), .ctrlB(ctrlB),
        .readData(readData), .split(split), .dxA(dxA), .dxB(dxB),
        .dxDataA(dxDataA), .dxDataB(dxDataB)
    );

    bypassAlu aluA (
        .dx(dxA), .regData(dxDataA), .xmA(xmA), .xmB(xmB),
        .mwA(mwA), .mwB(mwB), .result(resultA)
    );

    bypassAlu aluB (
        .dx(dxB), .regData(dxDataB), .xmA(xmA), .xmB(xmB),
        .mwA(mwA), .mwB(mwB), .result(resultB)
    );

    retireStage #(.counterWidth(counterWidth)) retire (
        .clock(clock), .reset(reset), .dxA(dxA), .dxB(dxB),
        .resultA(resultA), .resultB(resultB),
        .xmA(xmA), .xmB(xmB), .mwA(mwA), .mwB(mwB),
        .retireA(retireA), .retireB(retireB),
        .halted(halted), .counterOut(counterOut)
    );

endmodule

//--- verification/hazard_props.sv
module hazardProps #(
    parameter int heldWidth = 32
) (
    input logic                 clock,
    input logic                 reset,
    input logic                 split,
    input logic [heldWidth-1:0] heldValue   // must not move across a split
);

    // slot B re-enters decode exactly once
    splitHolds: assert property (@(posedge clock) disable iff (reset)
        split |=> $stable(heldValue))
        else $error("held value changed across a split");

    splitOnce: assert property (@(posedge clock) disable iff (reset)
        split |=> !split)
        else $error("split high for two cycles in a row");

endmodule

bind fetchUnit hazardProps #(.heldWidth(32)) fetchProps (
    .clock(clock), .reset(reset), .split(split), .heldValue(fetchAddr)
);

bind issueControl hazardProps #(.heldWidth($bits(pipePkg::slotCtrlT))) issueProps (
    .clock(clock), .reset(reset), .split(split), .heldValue(ctrlB)
);

//--- verification/coreTb.sv
module coreTb;

    localparam int             clockPeriod  = 40;
    localparam int             resetCycles  = 16;
    localparam int             counterWidth = 32;
    localparam int             progLength   = 200;
    localparam int             memWords     = 512;
    localparam rvIsaPkg::wordT pcBase       = 32'h0000_0100;
    localparam rvIsaPkg::wordT haltWord     = {25'b0, rvIsaPkg::opHalt};
    localparam logic [31:0]    lfsrTaps     = 32'hD000_0001;

    logic                    clock;
    logic                    reset;
    rvIsaPkg::wordT          fetchAddr;
    pipePkg::packetT         fetchPacket;
    pipePkg::retireT         retireA;
    pipePkg::retireT         retireB;
    logic                    halted;
    logic [counterWidth-1:0] counterOut;

    rvIsaPkg::wordT  prog [memWords];
    logic [8:0]      fetchIdx;
    rvIsaPkg::wordT  modelRegs [32];
    pipePkg::retireT expQ [$];  // model writes in program order
    logic [31:0]     lfsrState;
    int              valueErrors;
    int              otherErrors;
    logic            verdictShown;

    // instruction memory behind the fetch port
    assign fetchIdx    = 9'((fetchAddr - pcBase) >> 2);
    assign fetchPacket = '{slotA: prog[fetchIdx], slotB: prog[fetchIdx + 9'd1]};

    dualIssueCore #(.pcResetValue(pcBase), .counterWidth(counterWidth)) i_dut (
        .clock(clock), .reset(reset), .fetchAddr(fetchAddr), .fetchPacket(fetchPacket),
        .retireA(retireA), .retireB(retireB), .halted(halted), .counterOut(counterOut)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // random program and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] randBits(int count);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            out       = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (out ? lfsrTaps : 32'h0);
            bits      = {bits[30:0], out};
        end
        return bits;
    endfunction

    function automatic void modelStep(rvIsaPkg::wordT instr);
        rvIsaPkg::wordT    a;
        rvIsaPkg::wordT    b;
        rvIsaPkg::wordT    value;
        rvIsaPkg::regAddrT rd;
        logic              isReg;
        rd    = instr[11:7];
        isReg = (instr[6:0] == rvIsaPkg::opOp);
        a     = modelRegs[instr[19:15]];
        b     = isReg ? modelRegs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        case (instr[14:12])
            3'd0:    value = (isReg && instr[30]) ? a - b : a + b;
            3'd1:    value = a << b[4:0];
            3'd2:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    value = (a < b) ? 32'd1 : 32'd0;
            3'd4:    value = a ^ b;
            3'd5:    value = instr[30] ? rvIsaPkg::wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    value = a | b;
            default: value = a & b;
        endcase
        if (instr[6:0] == rvIsaPkg::opLui) begin
            value = {instr[31:12], 12'h000};
        end
        if (rd != 5'd0) begin  // x0 stays zero
            modelRegs[rd] = value;
            expQ.push_back('{valid: 1'b1, rd: rd, data: value});
        end
    endfunction

    task automatic buildProgram();
        logic [1:0]        kind;
        logic [2:0]        f3;
        logic [6:0]        f7;
        rvIsaPkg::regAddrT rd;
        rvIsaPkg::regAddrT rs1;
        rvIsaPkg::regAddrT rs2;
        logic [11:0]       imm;
        lfsrState = 32'h3267;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int w = 0; w < memWords; w++) begin
            prog[w] = rvIsaPkg::nopWord;
        end
        for (int i = 0; i < progLength; i++) begin
            kind = 2'(randBits(2));
            f3   = 3'(randBits(3));
            rd   = 5'(randBits(3));  // x0..x7 only
            rs1  = 5'(randBits(3));
            rs2  = 5'(randBits(3));
            f7   = 7'b0;
            if ((f3 == 3'b000 || f3 == 3'b101) && randBits(1) == 32'd1) begin
                f7 = rvIsaPkg::f7Alt;  // sub or sra
            end
            if (kind == 2'd0) begin
                prog[i] = {f7, rs2, rs1, f3, rd, rvIsaPkg::opOp};
            end else if (kind == 2'd1) begin
                prog[i] = {20'(randBits(20)), rd, rvIsaPkg::opLui};
            end else begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {f7, 5'(randBits(5))};
                end else begin
                    imm = 12'(randBits(12));
                end
                prog[i] = {imm, rs1, f3, rd, rvIsaPkg::opOpImm};
            end
            modelStep(prog[i]);
        end
        prog[progLength] = haltWord;
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic checkRetire(string name, pipePkg::retireT got, pipePkg::retireT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error: %s got valid %h rd %h data %h, expected valid %h rd %h data %h",
                     name, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
        end
    endtask

    task automatic checkCounter(string name, logic [counterWidth-1:0] got,
                                logic [counterWidth-1:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkWord(string name, rvIsaPkg::wordT got, rvIsaPkg::wordT exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic matchRetire(string name, pipePkg::retireT got);
        if (expQ.size() == 0) begin
            otherErrors++;
            $display("%s retired x%0d with no model write left", name, got.rd);
        end else begin
            checkRetire(name, got, expQ.pop_front());
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        pipePkg::retireT zeroRetire;
        int              edgeCount;
        int              afterHalt;
        logic            haltSeen;
        zeroRetire   = '0;
        edgeCount    = 0;
        afterHalt    = 0;
        haltSeen     = 1'b0;
        valueErrors  = 0;
        otherErrors  = 0;
        verdictShown = 1'b0;
        reset        = 1'b1;
        buildProgram();
        repeat (resetCycles) @(posedge clock);
        #2 reset = 1'b0;
        #1;
        checkFlag("halted", halted, 1'b0);
        checkRetire("retireA", retireA, zeroRetire);
        checkRetire("retireB", retireB, zeroRetire);
        checkCounter("counterOut", counterOut, '0);
        checkWord("fetchAddr", fetchAddr, pcBase);
        while (afterHalt < 4) begin
            @(posedge clock);
            #2;
            edgeCount++;  // edges since reset release
            if (retireA.valid) begin
                matchRetire("retireA", retireA);
            end
            if (retireB.valid) begin
                matchRetire("retireB", retireB);  // younger of the pair
            end
            if (haltSeen) begin
                afterHalt++;
                if (!halted) begin
                    otherErrors++;
                    $display("halted dropped after it had risen");
                end
            end else if (halted) begin
                haltSeen = 1'b1;
                checkCounter("counterOut", counterOut, counterWidth'(edgeCount));
                if (expQ.size() != 0) begin
                    otherErrors++;
                    $display("%0d model writes never retired before halt", expQ.size());
                end
            end
        end
        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        verdictShown = 1'b1;
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #((resetCycles + progLength * 10) * clockPeriod);
        $display("timeout: halted not seen within %0d cycles", progLength * 10);
        $display("errors: %0d value, %0d other", valueErrors, otherErrors + 1);
        verdictShown = 1'b1;
        $display("Simulation FAILED");
        $finish;
    end

    final begin
        if (!verdictShown) begin
            $display("Simulation FAILED");
        end
    end

endmodule

//--- filelist.f
design/rvIsaPkg.sv
design/pipePkg.sv
design/fetchUnit.sv
design/decodeSlot.sv
design/regFile.sv
design/issueControl.sv
design/bypassAlu.sv
design/retireStage.sv
design/dualIssueCore.sv
verification/hazard_props.sv
verification/coreTb.sv

//--- runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -f filelist.f --top-module coreTb \
    -Mdir obj_dir -o coreSim
./obj_dir/coreSim | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run passed"
else
    echo "run failed, see sim.log"
    exit 1
fi
